// ==== filelist.f ====
+incdir+verification
rtl/palette_pkg.sv
rtl/colour_table.sv
rtl/pixel_lookup.sv
rtl/palette_top.sv
verification/tb_palette.sv

// ==== rtl/colour_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module colour_table import palette_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  // Write address channel
  input  axil_addr_t s_axil_awaddr,
  input  logic [2:0] s_axil_awprot,   // Not used
  input  logic       s_axil_awvalid,
  output logic       s_axil_awready,

  // Write data channel
  input  colour_t    s_axil_wdata,
  input  logic [1:0] s_axil_wstrb,    // Whole entry is always written
  input  logic       s_axil_wvalid,
  output logic       s_axil_wready,

  // Write response channel
  output logic [1:0] s_axil_bresp,
  output logic       s_axil_bvalid,
  input  logic       s_axil_bready,

  // Read address channel
  input  axil_addr_t s_axil_araddr,
  input  logic [2:0] s_axil_arprot,   // Not used
  input  logic       s_axil_arvalid,
  output logic       s_axil_arready,

  // Read data channel
  output colour_t    s_axil_rdata,
  output logic [1:0] s_axil_rresp,
  output logic       s_axil_rvalid,
  input  logic       s_axil_rready,

  // Lookup port
  input  pal_index_t lut_index,
  output colour_t    lut_colour
);

  // Palette storage, contents survive reset
  colour_t palette_ram [palette_depth];

  logic       aw_hs;
  logic       w_hs;
  logic       ar_hs;

  axil_addr_t aw_addr_q;
  axil_addr_t wr_addr;
  logic       w_pending;

  axil_addr_t ar_addr_q;
  logic       ar_pending;

  // Byte address to entry number, addresses outside the window wrap
  function automatic pal_index_t entry_of(axil_addr_t addr);
    axil_addr_t offset;
    offset = addr - palette_base;
    return offset[12:1];
  endfunction

  // Always ready on the request channels
  assign s_axil_awready = 1'b1;
  assign s_axil_wready  = 1'b1;
  assign s_axil_arready = 1'b1;

  // Every response is OKAY
  assign s_axil_bresp = 2'b00;
  assign s_axil_rresp = 2'b00;

  assign aw_hs = s_axil_awvalid & s_axil_awready;
  assign w_hs  = s_axil_wvalid & s_axil_wready;
  assign ar_hs = s_axil_arvalid & s_axil_arready;

  // Address may arrive with the data or ahead of it
  assign wr_addr = aw_hs ? s_axil_awaddr : aw_addr_q;

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      aw_addr_q <= s_axil_awaddr;
    end
  end

  // Write takes effect on the W handshake edge
  always_ff @(posedge aclk) begin
    if (w_hs) begin
      palette_ram[entry_of(wr_addr)] <= s_axil_wdata;
    end
  end

  // One cycle of delay between the write and its response
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_pending <= 1'b0;
    end else begin
      w_pending <= w_hs;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_bvalid <= 1'b0;
    end else if (w_pending) begin
      s_axil_bvalid <= 1'b1;
    end else if (s_axil_bready) begin
      s_axil_bvalid <= 1'b0;   // Response taken
    end
  end

  // Read address is held for the RAM access on the next edge
  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      ar_addr_q <= s_axil_araddr;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ar_pending <= 1'b0;
    end else begin
      ar_pending <= ar_hs;
    end
  end

  // Read data loads once per request and holds until taken
  always_ff @(posedge aclk) begin
    if (ar_pending) begin
      s_axil_rdata <= palette_ram[entry_of(ar_addr_q)];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_rvalid <= 1'b0;
    end else if (ar_pending) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

  // Second read port for the pixel path
  // Reads every cycle so a stalled index keeps its colour fresh
  always_ff @(posedge aclk) begin
    lut_colour <= palette_ram[lut_index];
  end

endmodule

`default_nettype wire

// ==== rtl/palette_pkg.sv ====
`default_nettype none

package palette_pkg;

  // Bus byte address
  typedef logic [15:0] axil_addr_t;

  // RGB565 colour, also the bus data width
  typedef logic [15:0] colour_t;

  // Palette entry number
  typedef logic [11:0] pal_index_t;

  localparam int palette_depth = 4096;

  // Byte address of entry 0, entries are two bytes apart
  localparam axil_addr_t palette_base = 16'h2000;

  // Pixel index entering the lookup stage
  typedef struct packed {
    pal_index_t index;
    logic       last;   // End of line
  } pixel_in_t;

  // Colour leaving the lookup stage
  typedef struct packed {
    colour_t colour;
    logic    last;      // End of line
  } pixel_out_t;

endpackage

`default_nettype wire

// ==== rtl/palette_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module palette_top import palette_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  // AXI4-Lite slave
  input  axil_addr_t s_axil_awaddr,
  input  logic [2:0] s_axil_awprot,
  input  logic       s_axil_awvalid,
  output logic       s_axil_awready,
  input  colour_t    s_axil_wdata,
  input  logic [1:0] s_axil_wstrb,
  input  logic       s_axil_wvalid,
  output logic       s_axil_wready,
  output logic [1:0] s_axil_bresp,
  output logic       s_axil_bvalid,
  input  logic       s_axil_bready,
  input  axil_addr_t s_axil_araddr,
  input  logic [2:0] s_axil_arprot,
  input  logic       s_axil_arvalid,
  output logic       s_axil_arready,
  output colour_t    s_axil_rdata,
  output logic [1:0] s_axil_rresp,
  output logic       s_axil_rvalid,
  input  logic       s_axil_rready,

  // Pixel streams
  input  pixel_in_t  pix_in,
  input  logic       pix_in_valid,
  output logic       pix_in_ready,
  output pixel_out_t pix_out,
  output logic       pix_out_valid,
  input  logic       pix_out_ready
);

  pal_index_t lut_index;
  colour_t    lut_colour;

  colour_table colour_table_i (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awprot  (s_axil_awprot),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arprot  (s_axil_arprot),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .lut_index      (lut_index),
    .lut_colour     (lut_colour)
  );

  // Lookup pipeline on the palette's second port
  pixel_lookup pixel_lookup_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .pix_in        (pix_in),
    .pix_in_valid  (pix_in_valid),
    .pix_in_ready  (pix_in_ready),
    .pix_out       (pix_out),
    .pix_out_valid (pix_out_valid),
    .pix_out_ready (pix_out_ready),
    .lut_index     (lut_index),
    .lut_colour    (lut_colour)
  );

endmodule

`default_nettype wire

// ==== rtl/pixel_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_lookup import palette_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  // Pixel index stream in
  input  pixel_in_t  pix_in,
  input  logic       pix_in_valid,
  output logic       pix_in_ready,

  // Colour stream out
  output pixel_out_t pix_out,
  output logic       pix_out_valid,
  input  logic       pix_out_ready,

  // Palette lookup port
  output pal_index_t lut_index,
  input  colour_t    lut_colour
);

  // Stage one holds the index whose colour is being read
  pixel_in_t s1_pix;
  logic      s1_valid;

  // Both stages move together
  logic advance;

  // Output register is free or being emptied this cycle
  assign advance = pix_out_ready | ~pix_out_valid;

  assign pix_in_ready = advance;

  // Present the incoming index when moving, else re-read the held one
  assign lut_index = advance ? pix_in.index : s1_pix.index;

  always_ff @(posedge aclk) begin
    if (advance) begin
      s1_pix <= pix_in;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= pix_in_valid;   // Bubble when no input
    end
  end

  // Stage two takes the colour read for stage one
  always_ff @(posedge aclk) begin
    if (advance) begin
      pix_out.colour <= lut_colour;
      pix_out.last   <= s1_pix.last;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pix_out_valid <= 1'b0;
    end else if (advance) begin
      pix_out_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the palette testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_palette -f filelist.f -o tb_palette_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_palette_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }

// ==== verification/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row holds an operation, a bus address or start index, data or a pixel count
// and the expected value
// Reads expect a colour and bursts expect the number of end-of-line flags

typedef enum logic [1:0] {
  op_write,       // One palette entry over the bus
  op_read,        // Bus read with compare
  op_burst,       // Pixel burst with the output always ready
  op_burst_rand   // Pixel burst with random valid and ready
} op_t;

typedef struct packed {
  op_t         op;
  axil_addr_t  addr;
  logic [15:0] data;
  logic [15:0] expected;
} vector_t;

localparam int num_vectors = 29;

localparam vector_t vectors [num_vectors] = '{
  '{op_write,      16'h2000, 16'h001F, 16'h0000},   // Entry 0
  '{op_write,      16'h2002, 16'h07E0, 16'h0000},
  '{op_write,      16'h2004, 16'hF800, 16'h0000},
  '{op_write,      16'h2006, 16'hFFFF, 16'h0000},
  '{op_write,      16'h2008, 16'h1234, 16'h0000},
  '{op_write,      16'h200A, 16'h8421, 16'h0000},
  '{op_write,      16'h200C, 16'h5A5A, 16'h0000},
  '{op_write,      16'h200E, 16'hA5A5, 16'h0000},
  '{op_write,      16'h3FFC, 16'h0F0F, 16'h0000},
  '{op_write,      16'h3FFE, 16'hF0F0, 16'h0000},   // Entry 4095
  '{op_read,       16'h2000, 16'h0000, 16'h001F},
  '{op_read,       16'h2002, 16'h0000, 16'h07E0},
  '{op_read,       16'h2004, 16'h0000, 16'hF800},
  '{op_read,       16'h2006, 16'h0000, 16'hFFFF},
  '{op_read,       16'h2008, 16'h0000, 16'h1234},
  '{op_read,       16'h200A, 16'h0000, 16'h8421},
  '{op_read,       16'h200C, 16'h0000, 16'h5A5A},
  '{op_read,       16'h200E, 16'h0000, 16'hA5A5},
  '{op_read,       16'h3FFC, 16'h0000, 16'h0F0F},
  '{op_read,       16'h3FFE, 16'h0000, 16'hF0F0},
  '{op_burst,      16'h0000, 16'd8,    16'd2},
  '{op_burst,      16'h0FFE, 16'd6,    16'd2},      // Wraps past entry 4095
  '{op_burst_rand, 16'h0000, 16'd8,    16'd2},
  '{op_burst_rand, 16'h0FFE, 16'd10,   16'd3},
  '{op_write,      16'h2004, 16'hBEEF, 16'h0000},   // Rewrite entry 2
  '{op_read,       16'h2004, 16'h0000, 16'hBEEF},
  '{op_burst,      16'h0000, 16'd8,    16'd2},
  '{op_burst_rand, 16'h0000, 16'd8,    16'd2},
  '{op_burst_rand, 16'h0FFE, 16'd6,    16'd2}
};

`endif

// ==== verification/tb_palette.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_palette import palette_pkg::*; ();

  logic       aclk;
  logic       aresetn;
  axil_addr_t s_axil_awaddr;
  logic [2:0] s_axil_awprot;
  logic       s_axil_awvalid;
  logic       s_axil_awready;
  colour_t    s_axil_wdata;
  logic [1:0] s_axil_wstrb;
  logic       s_axil_wvalid;
  logic       s_axil_wready;
  logic [1:0] s_axil_bresp;
  logic       s_axil_bvalid;
  logic       s_axil_bready;
  axil_addr_t s_axil_araddr;
  logic [2:0] s_axil_arprot;
  logic       s_axil_arvalid;
  logic       s_axil_arready;
  colour_t    s_axil_rdata;
  logic [1:0] s_axil_rresp;
  logic       s_axil_rvalid;
  logic       s_axil_rready;
  pixel_in_t  pix_in;
  logic       pix_in_valid;
  logic       pix_in_ready;
  pixel_out_t pix_out;
  logic       pix_out_valid;
  logic       pix_out_ready;

  `include "tb_vectors.svh"

  localparam int wait_limit = 50;   // Cycles per bus wait

  integer     seed;
  colour_t    shadow [palette_depth];   // Model of the palette
  pixel_out_t expected_q [$];
  int         checks;
  int         errors;
  int         timeouts;

  palette_top palette_top_i (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Entry n lives at palette_base + 2n
  function automatic pal_index_t entry_from_addr(input axil_addr_t addr);
    axil_addr_t offset;
    offset = addr - palette_base;
    return pal_index_t'(offset >> 1);
  endfunction

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic check_reset_state();
    checks++;
    if (s_axil_bvalid !== 1'b0 || s_axil_rvalid !== 1'b0 || pix_out_valid !== 1'b0) begin
      errors++;
      $display("error at %0t: not idle after reset, bvalid %b rvalid %b pix_out_valid %b",
               $time, s_axil_bvalid, s_axil_rvalid, pix_out_valid);
    end
  endtask

  task automatic write_entry(input axil_addr_t addr, input colour_t data);
    int wait_cycles;
    @(negedge aclk);
    s_axil_awaddr  = addr;   // Address goes with the data
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wvalid  = 1'b1;
    wait_cycles = 0;
    #1;
    while (!(s_axil_awready && s_axil_wready) && wait_cycles < wait_limit) begin
      @(negedge aclk);
      #1;
      wait_cycles++;
    end
    if (!(s_axil_awready && s_axil_wready)) report_timeout("awready and wready");
    @(negedge aclk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    wait_cycles = 0;
    while (!s_axil_bvalid && wait_cycles < wait_limit) begin
      @(negedge aclk);
      wait_cycles++;
    end
    if (!s_axil_bvalid) begin
      report_timeout("bvalid");
    end else begin
      checks++;
      if (s_axil_bresp !== 2'b00) begin
        errors++;
        $display("error at %0t: bresp %b on write to 0x%04h", $time, s_axil_bresp, addr);
      end
    end
    shadow[entry_from_addr(addr)] = data;
  endtask

  task automatic read_entry(input axil_addr_t addr, input colour_t expected);
    int wait_cycles;
    @(negedge aclk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    wait_cycles = 0;
    #1;
    while (!s_axil_arready && wait_cycles < wait_limit) begin
      @(negedge aclk);
      #1;
      wait_cycles++;
    end
    if (!s_axil_arready) report_timeout("arready");
    @(negedge aclk);
    s_axil_arvalid = 1'b0;
    wait_cycles = 0;
    while (!s_axil_rvalid && wait_cycles < wait_limit) begin
      @(negedge aclk);
      wait_cycles++;
    end
    if (!s_axil_rvalid) begin
      report_timeout("rvalid");
    end else begin
      checks++;
      if (s_axil_rdata !== expected || s_axil_rresp !== 2'b00) begin
        errors++;
        $display("error at %0t: read 0x%04h got 0x%04h rresp %b, expected 0x%04h",
                 $time, addr, s_axil_rdata, s_axil_rresp, expected);
      end
    end
  endtask

  // Drives one burst and checks each colour as it leaves
  task automatic run_burst(input pal_index_t start, input int count, input bit randomized,
                           input int expected_lasts);
    int         sent;
    int         received;
    int         lasts_seen;
    int         cycles;
    integer     rnd;
    bit         in_pending;
    bit         stalled;
    pixel_out_t held;
    pixel_out_t want;
    sent = 0;
    received = 0;
    lasts_seen = 0;
    cycles = 0;
    in_pending = 1'b0;
    stalled = 1'b0;
    held = '0;
    expected_q.delete();
    while (received < count && cycles < count * 20 + wait_limit) begin
      @(negedge aclk);
      rnd = $random(seed);
      pix_out_ready = randomized ? rnd[0] : 1'b1;
      if (!in_pending && sent < count && (!randomized || rnd[1])) begin
        pix_in.index = start + 12'(sent);
        pix_in.last  = (sent % 4 == 3) || (sent == count - 1);   // Line of four pixels
        pix_in_valid = 1'b1;
        in_pending   = 1'b1;
      end else if (!in_pending) begin
        pix_in_valid = 1'b0;
      end
      #1;
      if (stalled) begin
        checks++;
        if (pix_out_valid !== 1'b1 || pix_out !== held) begin
          errors++;
          $display("error at %0t: pix_out changed while stalled", $time);
        end
      end
      if (pix_in_valid && pix_in_ready) begin
        expected_q.push_back('{colour: shadow[pix_in.index], last: pix_in.last});
        sent++;
        in_pending = 1'b0;
      end
      if (pix_out_valid && pix_out_ready) begin
        checks++;
        if (expected_q.size() == 0) begin
          errors++;
          $display("error at %0t: pixel out with none expected", $time);
        end else begin
          want = expected_q.pop_front();
          if (pix_out !== want) begin
            errors++;
            $display("error at %0t: pixel %0d got 0x%04h last %b, expected 0x%04h last %b",
                     $time, received, pix_out.colour, pix_out.last, want.colour, want.last);
          end
        end
        if (pix_out.last) lasts_seen++;
        received++;
      end
      stalled = pix_out_valid && !pix_out_ready;
      held = pix_out;
      cycles++;
    end
    if (received < count) report_timeout("the rest of the pixel burst");
    @(negedge aclk);
    pix_in_valid  = 1'b0;
    pix_out_ready = 1'b1;
    repeat (3) begin
      #1;
      checks++;
      if (pix_out_valid !== 1'b0) begin
        errors++;
        $display("error at %0t: extra pixel after the burst", $time);
      end
      @(negedge aclk);
    end
    checks++;
    if (lasts_seen != expected_lasts) begin
      errors++;
      $display("error at %0t: %0d end-of-line flags, expected %0d",
               $time, lasts_seen, expected_lasts);
    end
  endtask

  task automatic apply_vector(input vector_t v);
    case (v.op)
      op_write:      write_entry(v.addr, v.data);
      op_read:       read_entry(v.addr, v.expected);
      op_burst:      run_burst(v.addr[11:0], int'(v.data), 1'b0, int'(v.expected));
      op_burst_rand: run_burst(v.addr[11:0], int'(v.data), 1'b1, int'(v.expected));
      default: ;
    endcase
  endtask

  initial begin
    aresetn        = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awprot  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = 2'b11;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;   // Responses taken as soon as they show
    s_axil_araddr  = '0;
    s_axil_arprot  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    pix_in         = '0;
    pix_in_valid   = 1'b0;
    pix_out_ready  = 1'b1;
    seed     = 82477;
    checks   = 0;
    errors   = 0;
    timeouts = 0;

    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    check_reset_state();

    for (int i = 0; i < num_vectors; i++) begin
      apply_vector(vectors[i]);
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
